// File: common/cache_pkg.sv
`default_nettype none

package cache_pkg;

        // address and data width
        localparam int WORD_W = 32;

        // address fields: tag [31:6], index [5:3], block offset [2]
        localparam int TAG_W = 26;
        localparam int IDX_W = 3;

        // geometry
        localparam int SETS = 8;
        localparam int WAYS = 2;

        // posted write buffer
        localparam int WBUF_DEPTH = 4;
        localparam int WBUF_PTR_W = $clog2(WBUF_DEPTH);
        localparam int WBUF_CNT_W = $clog2(WBUF_DEPTH + 1);

        // hit count lands here after the halt flush
        localparam logic [WORD_W-1:0] HIT_COUNT_ADDR = 32'h3100;

        typedef enum logic [3:0] {
                LOOKUP,
                WB_WORD0,
                WB_WORD1,
                FILL_WORD0,
                FILL_WORD1,
                FLUSH_SCAN,
                FLUSH_WORD0,
                FLUSH_WORD1,
                STORE_COUNT,
                DRAIN,
                FLUSHED
        } dcache_state_t;

        typedef enum logic [1:0] {
                IDLE,
                SETUP,
                ACCESS
        } apb_phase_t;

endpackage

`default_nettype wire

// File: dcache/dcache.sv
`timescale 1ns/10ps
`default_nettype none

module dcache (
        input  logic                          CLK,
        input  logic                          nRST,
        input  logic                          dmemren,
        input  logic                          dmemwen,
        input  logic [cache_pkg::WORD_W-1:0]  dmemaddr,
        input  logic [cache_pkg::WORD_W-1:0]  dmemstore,
        input  logic                          halt,
        input  logic                          wbuf_full,
        input  logic                          wbuf_empty,
        input  logic                          rd_valid,
        input  logic [cache_pkg::WORD_W-1:0]  rd_data,
        output logic [cache_pkg::WORD_W-1:0]  dmemload,
        output logic                          dhit,
        output logic                          flushed,
        output logic                          wb_push,
        output logic [cache_pkg::WORD_W-1:0]  wb_push_addr,
        output logic [cache_pkg::WORD_W-1:0]  wb_push_data,
        output logic                          rd_req,
        output logic [cache_pkg::WORD_W-1:0]  rd_addr
);
        import cache_pkg::*;

        dcache_state_t state, next_state;

        logic [WAYS-1:0][SETS-1:0] valid;
        logic [WAYS-1:0][SETS-1:0] dirty;
        logic [SETS-1:0]           lru;
        logic [TAG_W-1:0]          tag_arr [WAYS][SETS];
        logic [WORD_W-1:0]         data_arr [WAYS][SETS][2];
        logic [WORD_W-1:0]         hit_count;

        // line being written back, filled or flushed
        logic [IDX_W-1:0] cur_idx;
        logic             cur_way;

        logic [TAG_W-1:0] req_tag;
        logic [IDX_W-1:0] req_idx;
        logic             req_blk;
        logic [WAYS-1:0]  way_hit;
        logic             hit_way;
        logic             victim;
        logic             victim_dirty;
        logic             miss;
        logic             pushing;
        logic             push_word;
        logic             fill_word;
        logic             line_dirty;
        logic             last_line;

        assign req_tag = dmemaddr[WORD_W-1 -: TAG_W];
        assign req_idx = dmemaddr[IDX_W+2:3];
        assign req_blk = dmemaddr[2];

        always_comb begin
                for (int w = 0; w < WAYS; w++) begin
                        way_hit[w] = valid[w][req_idx] && (tag_arr[w][req_idx] == req_tag);
                end
        end

        assign hit_way      = way_hit[1];
        assign victim       = lru[req_idx];
        assign victim_dirty = valid[victim][req_idx] && dirty[victim][req_idx];

        assign dhit = (state == LOOKUP) && !halt && (dmemren || dmemwen) && (|way_hit);
        assign miss = (state == LOOKUP) && !halt && (dmemren || dmemwen) && !(|way_hit);
        assign dmemload = data_arr[hit_way][req_idx][req_blk];
        assign flushed  = (state == FLUSHED);

        // push side toward the write buffer
        assign pushing = (state == WB_WORD0) || (state == WB_WORD1) ||
                         (state == FLUSH_WORD0) || (state == FLUSH_WORD1) ||
                         (state == STORE_COUNT);
        assign push_word = (state == WB_WORD1) || (state == FLUSH_WORD1);
        assign wb_push   = pushing && !wbuf_full;

        always_comb begin
                if (state == STORE_COUNT) begin
                        wb_push_addr = HIT_COUNT_ADDR;
                        wb_push_data = hit_count;
                end else begin
                        wb_push_addr = {tag_arr[cur_way][cur_idx], cur_idx, push_word, 2'b00};
                        wb_push_data = data_arr[cur_way][cur_idx][push_word];
                end
        end

        // fill reads use the held request address
        assign fill_word = (state == FILL_WORD1);
        assign rd_req    = (state == FILL_WORD0) || (state == FILL_WORD1);
        assign rd_addr   = {dmemaddr[WORD_W-1:3], fill_word, 2'b00};

        assign line_dirty = valid[cur_way][cur_idx] && dirty[cur_way][cur_idx];
        assign last_line  = (cur_idx == IDX_W'(SETS - 1)) && cur_way;

        always_comb begin
                next_state = state;
                case (state)
                        LOOKUP: begin
                                if (halt)
                                        next_state = FLUSH_SCAN;
                                else if (miss)
                                        next_state = victim_dirty ? WB_WORD0 : FILL_WORD0;
                        end
                        WB_WORD0:    if (!wbuf_full) next_state = WB_WORD1;
                        WB_WORD1:    if (!wbuf_full) next_state = FILL_WORD0;
                        FILL_WORD0:  if (rd_valid) next_state = FILL_WORD1;
                        FILL_WORD1:  if (rd_valid) next_state = LOOKUP;
                        FLUSH_SCAN: begin
                                if (line_dirty)
                                        next_state = FLUSH_WORD0;
                                else if (last_line)
                                        next_state = STORE_COUNT;
                        end
                        FLUSH_WORD0: if (!wbuf_full) next_state = FLUSH_WORD1;
                        FLUSH_WORD1: if (!wbuf_full) next_state = FLUSH_SCAN;
                        STORE_COUNT: if (!wbuf_full) next_state = DRAIN;
                        // pop happens as the last APB write completes
                        DRAIN:       if (wbuf_empty) next_state = FLUSHED;
                        FLUSHED:     next_state = FLUSHED;
                        default:     next_state = LOOKUP;
                endcase
        end

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state     <= LOOKUP;
                        valid     <= '0;
                        dirty     <= '0;
                        lru       <= '0;
                        hit_count <= '0;
                        cur_idx   <= '0;
                        cur_way   <= 1'b0;
                end else begin
                        state <= next_state;
                        if (dhit) begin
                                hit_count    <= hit_count + 1'b1;
                                lru[req_idx] <= ~hit_way;
                                if (dmemwen)
                                        dirty[hit_way][req_idx] <= 1'b1;
                        end
                        // the retry after the fill hits again
                        if (miss) begin
                                hit_count <= hit_count - 1'b1;
                                cur_idx   <= req_idx;
                                cur_way   <= victim;
                        end
                        if ((state == LOOKUP) && halt) begin
                                cur_idx <= '0;
                                cur_way <= 1'b0;
                        end
                        // way 0 then way 1 of each set
                        if ((state == FLUSH_SCAN) && !line_dirty)
                                {cur_idx, cur_way} <= {cur_idx, cur_way} + 1'b1;
                        if ((state == FLUSH_WORD1) && !wbuf_full)
                                dirty[cur_way][cur_idx] <= 1'b0;
                        if ((state == FILL_WORD1) && rd_valid) begin
                                valid[cur_way][cur_idx] <= 1'b1;
                                dirty[cur_way][cur_idx] <= 1'b0;
                        end
                        if (state == FLUSHED) begin
                                valid <= '0;
                                dirty <= '0;
                        end
                end
        end

        always_ff @(posedge CLK) begin
                if (dhit && dmemwen)
                        data_arr[hit_way][req_idx][req_blk] <= dmemstore;
                if (rd_req && rd_valid)
                        data_arr[cur_way][cur_idx][fill_word] <= rd_data;
                if ((state == FILL_WORD1) && rd_valid)
                        tag_arr[cur_way][cur_idx] <= req_tag;
        end

endmodule

`default_nettype wire

// File: dcache_top.f
common/cache_pkg.sv
dcache/dcache.sv
source/write_buffer.sv
source/apb_mem_master.sv
source/dcache_top.sv
testbench/apb_mem_model.sv
testbench/tb_dcache_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps \
        -f dcache_top.f --top-module tb_dcache_top -o sim_dcache

./obj_dir/sim_dcache | tee sim.log

if grep -qx "Simulation passed" sim.log; then
        echo "run_sim: PASS"
else
        echo "run_sim: FAIL"
        exit 1
fi

// File: source/apb_mem_master.sv
`timescale 1ns/10ps
`default_nettype none

module apb_mem_master (
        input  logic                          CLK,
        input  logic                          nRST,
        input  logic                          wbuf_empty,
        input  logic [cache_pkg::WORD_W-1:0]  wb_head_addr,
        input  logic [cache_pkg::WORD_W-1:0]  wb_head_data,
        input  logic                          rd_req,
        input  logic [cache_pkg::WORD_W-1:0]  rd_addr,
        input  logic [cache_pkg::WORD_W-1:0]  prdata,
        input  logic                          pready,
        output logic                          wb_pop,
        output logic                          rd_valid,
        output logic [cache_pkg::WORD_W-1:0]  rd_data,
        output logic                          psel,
        output logic                          penable,
        output logic                          pwrite,
        output logic [cache_pkg::WORD_W-1:0]  paddr,
        output logic [cache_pkg::WORD_W-1:0]  pwdata
);
        import cache_pkg::*;

        apb_phase_t phase;
        logic       is_write;
        logic       start_write;
        logic       start_read;

        // buffered writes first, reads only once the buffer is drained
        assign start_write = (phase == IDLE) && !wbuf_empty;
        // rd_req is still up while the last rd_valid is seen
        assign start_read  = (phase == IDLE) && wbuf_empty && rd_req && !rd_valid;

        assign psel    = (phase != IDLE);
        assign penable = (phase == ACCESS);
        assign pwrite  = psel && is_write;
        assign wb_pop  = penable && pready && is_write;

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        phase    <= IDLE;
                        is_write <= 1'b0;
                        rd_valid <= 1'b0;
                end else begin
                        rd_valid <= 1'b0;
                        case (phase)
                                IDLE: begin
                                        if (start_write || start_read) begin
                                                phase    <= SETUP;
                                                is_write <= start_write;
                                        end
                                end
                                SETUP: phase <= ACCESS;
                                ACCESS: begin
                                        if (pready) begin
                                                phase    <= IDLE;
                                                rd_valid <= !is_write;
                                        end
                                end
                                default: phase <= IDLE;
                        endcase
                end
        end

        always_ff @(posedge CLK) begin
                if (start_write) begin
                        paddr  <= wb_head_addr;
                        pwdata <= wb_head_data;
                end else if (start_read) begin
                        paddr <= rd_addr;
                end
                if (penable && pready)
                        rd_data <= prdata;
        end

endmodule

`default_nettype wire

// File: source/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
        input  logic                          CLK,
        input  logic                          nRST,
        input  logic                          dmemren,
        input  logic                          dmemwen,
        input  logic [cache_pkg::WORD_W-1:0]  dmemaddr,
        input  logic [cache_pkg::WORD_W-1:0]  dmemstore,
        input  logic                          halt,
        output logic [cache_pkg::WORD_W-1:0]  dmemload,
        output logic                          dhit,
        output logic                          flushed,
        output logic                          psel,
        output logic                          penable,
        output logic                          pwrite,
        output logic [cache_pkg::WORD_W-1:0]  paddr,
        output logic [cache_pkg::WORD_W-1:0]  pwdata,
        input  logic [cache_pkg::WORD_W-1:0]  prdata,
        input  logic                          pready
);
        import cache_pkg::*;

        logic              wb_push;
        logic [WORD_W-1:0] wb_push_addr;
        logic [WORD_W-1:0] wb_push_data;
        logic              wb_pop;
        logic [WORD_W-1:0] wb_head_addr;
        logic [WORD_W-1:0] wb_head_data;
        logic              wbuf_full;
        logic              wbuf_empty;
        logic              rd_req;
        logic [WORD_W-1:0] rd_addr;
        logic              rd_valid;
        logic [WORD_W-1:0] rd_data;

        dcache dcache_inst (
                .CLK          (CLK),
                .nRST         (nRST),
                .dmemren      (dmemren),
                .dmemwen      (dmemwen),
                .dmemaddr     (dmemaddr),
                .dmemstore    (dmemstore),
                .halt         (halt),
                .wbuf_full    (wbuf_full),
                .wbuf_empty   (wbuf_empty),
                .rd_valid     (rd_valid),
                .rd_data      (rd_data),
                .dmemload     (dmemload),
                .dhit         (dhit),
                .flushed      (flushed),
                .wb_push      (wb_push),
                .wb_push_addr (wb_push_addr),
                .wb_push_data (wb_push_data),
                .rd_req       (rd_req),
                .rd_addr      (rd_addr)
        );

        write_buffer write_buffer_inst (
                .CLK          (CLK),
                .nRST         (nRST),
                .wb_push      (wb_push),
                .wb_push_addr (wb_push_addr),
                .wb_push_data (wb_push_data),
                .wb_pop       (wb_pop),
                .wb_head_addr (wb_head_addr),
                .wb_head_data (wb_head_data),
                .wbuf_full    (wbuf_full),
                .wbuf_empty   (wbuf_empty)
        );

        apb_mem_master apb_mem_master_inst (
                .CLK          (CLK),
                .nRST         (nRST),
                .wbuf_empty   (wbuf_empty),
                .wb_head_addr (wb_head_addr),
                .wb_head_data (wb_head_data),
                .rd_req       (rd_req),
                .rd_addr      (rd_addr),
                .prdata       (prdata),
                .pready       (pready),
                .wb_pop       (wb_pop),
                .rd_valid     (rd_valid),
                .rd_data      (rd_data),
                .psel         (psel),
                .penable      (penable),
                .pwrite       (pwrite),
                .paddr        (paddr),
                .pwdata       (pwdata)
        );

endmodule

`default_nettype wire

// File: source/write_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module write_buffer (
        input  logic                          CLK,
        input  logic                          nRST,
        input  logic                          wb_push,
        input  logic [cache_pkg::WORD_W-1:0]  wb_push_addr,
        input  logic [cache_pkg::WORD_W-1:0]  wb_push_data,
        input  logic                          wb_pop,
        output logic [cache_pkg::WORD_W-1:0]  wb_head_addr,
        output logic [cache_pkg::WORD_W-1:0]  wb_head_data,
        output logic                          wbuf_full,
        output logic                          wbuf_empty
);
        import cache_pkg::*;

        logic [WORD_W-1:0]     addr_mem [WBUF_DEPTH];
        logic [WORD_W-1:0]     data_mem [WBUF_DEPTH];
        logic [WBUF_PTR_W-1:0] wr_ptr;
        logic [WBUF_PTR_W-1:0] rd_ptr;
        logic [WBUF_CNT_W-1:0] count;

        assign wbuf_full    = (count == WBUF_CNT_W'(WBUF_DEPTH));
        assign wbuf_empty   = (count == '0);
        assign wb_head_addr = addr_mem[rd_ptr];
        assign wb_head_data = data_mem[rd_ptr];

        // pointers wrap on their own, depth is a power of two
        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (wb_push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (wb_pop)
                                rd_ptr <= rd_ptr + 1'b1;
                        count <= count + WBUF_CNT_W'(wb_push) - WBUF_CNT_W'(wb_pop);
                end
        end

        always_ff @(posedge CLK) begin
                if (wb_push) begin
                        addr_mem[wr_ptr] <= wb_push_addr;
                        data_mem[wr_ptr] <= wb_push_data;
                end
        end

endmodule

`default_nettype wire

// File: testbench/apb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module apb_mem_model (
        input  logic                          CLK,
        input  logic                          nRST,
        input  logic                          psel,
        input  logic                          penable,
        input  logic                          pwrite,
        input  logic [cache_pkg::WORD_W-1:0]  paddr,
        input  logic [cache_pkg::WORD_W-1:0]  pwdata,
        output logic [cache_pkg::WORD_W-1:0]  prdata,
        output logic                          pready
);
        import cache_pkg::*;

        localparam int MEM_WORDS = 4096;

        logic [WORD_W-1:0] mem [MEM_WORDS];
        logic [31:0]       lcg_state;
        logic [1:0]        wait_left;

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        // each word starts as its own address with a marker in the upper half
        initial begin
                for (int i = 0; i < MEM_WORDS; i++)
                        mem[i] = (32'(i) << 2) ^ 32'h5a5a0000;
        end

        assign pready = psel && penable && (wait_left == 2'd0);

        always @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        lcg_state <= 32'h2b57;
                        wait_left <= 2'd0;
                        prdata    <= '0;
                end else if (psel && !penable) begin
                        // zero to three wait states per transfer
                        lcg_state <= lcg_next(lcg_state);
                        wait_left <= lcg_state[17:16];
                        prdata    <= mem[paddr[13:2]];
                end else if (psel && penable && (wait_left != 2'd0)) begin
                        wait_left <= wait_left - 2'd1;
                end
        end

        always @(posedge CLK) begin
                if (psel && penable && pready && pwrite)
                        mem[paddr[13:2]] <= pwdata;
        end

endmodule

`default_nettype wire

// File: testbench/tb_dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dcache_top;
        import cache_pkg::*;

        localparam int RANDOM_OPS   = 200;
        localparam int MAX_ACCESSES = 220;
        // up to four buffered writes and two reads, six cycles per APB transfer
        localparam int MISS_CYCLES  = 48;
        localparam int FLUSH_CYCLES = (SETS * WAYS * 2 + 1) * 8 + SETS * WAYS * 2;
        localparam int CYCLE_LIMIT  = 10 + MAX_ACCESSES * MISS_CYCLES + FLUSH_CYCLES + 100;

        logic              CLK = 1'b0;
        logic              nRST;
        logic              dmemren;
        logic              dmemwen;
        logic [WORD_W-1:0] dmemaddr;
        logic [WORD_W-1:0] dmemstore;
        logic              halt;
        logic [WORD_W-1:0] dmemload;
        logic              dhit;
        logic              flushed;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [WORD_W-1:0] paddr;
        logic [WORD_W-1:0] pwdata;
        logic [WORD_W-1:0] prdata;
        logic              pready;

        logic [WORD_W-1:0] ref_mem [logic [WORD_W-1:0]];
        logic [WORD_W-1:0] bus_img [logic [WORD_W-1:0]];
        logic [WORD_W-1:0] wr_addr_q [$];
        logic [WORD_W-1:0] wr_data_q [$];
        logic [31:0]       rand_state = 32'h2b57;
        int                hits = 0;
        int                cycles = 0;

        dcache_top dcache_top_inst (
                .CLK       (CLK),
                .nRST      (nRST),
                .dmemren   (dmemren),
                .dmemwen   (dmemwen),
                .dmemaddr  (dmemaddr),
                .dmemstore (dmemstore),
                .halt      (halt),
                .dmemload  (dmemload),
                .dhit      (dhit),
                .flushed   (flushed),
                .psel      (psel),
                .penable   (penable),
                .pwrite    (pwrite),
                .paddr     (paddr),
                .pwdata    (pwdata),
                .prdata    (prdata),
                .pready    (pready)
        );

        apb_mem_model apb_mem_model_inst (
                .CLK     (CLK),
                .nRST    (nRST),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .paddr   (paddr),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .pready  (pready)
        );

        always #4 CLK = ~CLK;

        always @(posedge CLK) begin
                cycles <= cycles + 1;
                if (cycles == CYCLE_LIMIT) begin
                        $display("timeout: the tests did not finish within %0d cycles", cycles);
                        $display("Simulation failed");
                        $fatal(1);
                end
        end

        // completed APB writes, sampled away from the clock edge
        always @(negedge CLK) begin
                if (psel && penable && pready && pwrite) begin
                        wr_addr_q.push_back(paddr);
                        wr_data_q.push_back(pwdata);
                        bus_img[paddr] = pwdata;
                end
        end

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        function automatic logic [WORD_W-1:0] ref_read(input logic [WORD_W-1:0] addr);
                return ref_mem.exists(addr) ? ref_mem[addr] : (addr ^ 32'h5a5a0000);
        endfunction

        function automatic logic [WORD_W-1:0] image_read(input logic [WORD_W-1:0] addr);
                return bus_img.exists(addr) ? bus_img[addr] : (addr ^ 32'h5a5a0000);
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        $display("ERROR at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
                        $display("Simulation failed");
                        $fatal(1);
                end
        endtask

        // one load or store, held until dhit
        task automatic mem_access(input logic wr, input logic [WORD_W-1:0] addr,
                                  input logic [WORD_W-1:0] wdata,
                                  output logic [WORD_W-1:0] rdata, output logic first_hit);
                int waited;
                waited = 0;
                @(negedge CLK);
                dmemren   = !wr;
                dmemwen   = wr;
                dmemaddr  = addr;
                dmemstore = wdata;
                #1;
                while (!dhit) begin
                        @(negedge CLK);
                        #1;
                        waited++;
                end
                rdata     = dmemload;
                first_hit = (waited == 0);
                if (first_hit)
                        hits++;
                if (wr)
                        ref_mem[addr] = wdata;
                @(negedge CLK);
                dmemren = 1'b0;
                dmemwen = 1'b0;
        endtask

        task automatic read_miss_then_hit();
                logic [WORD_W-1:0] rdata;
                logic              first_hit;
                mem_access(1'b0, 32'h100, '0, rdata, first_hit);
                check_value("cold read first lookup", 32'(first_hit), 32'd0);
                check_value("cold read data", rdata, ref_read(32'h100));
                mem_access(1'b0, 32'h100, '0, rdata, first_hit);
                check_value("warm read first lookup", 32'(first_hit), 32'd1);
                check_value("warm read data", rdata, ref_read(32'h100));
        endtask

        task automatic store_then_load();
                logic [WORD_W-1:0] rdata;
                logic              first_hit;
                mem_access(1'b1, 32'h208, 32'hcafe0001, rdata, first_hit);
                mem_access(1'b0, 32'h208, '0, rdata, first_hit);
                check_value("stored word", rdata, 32'hcafe0001);
                mem_access(1'b0, 32'h20c, '0, rdata, first_hit);
                check_value("neighbour word", rdata, ref_read(32'h20c));
        endtask

        // three tags on set 2, the first one dirty
        task automatic evict_dirty_line();
                logic [WORD_W-1:0] rdata;
                logic              first_hit;
                logic              seen;
                int                start;
                start = wr_addr_q.size();
                seen  = 1'b0;
                mem_access(1'b1, 32'h1010, 32'h1234abcd, rdata, first_hit);
                mem_access(1'b0, 32'h2010, '0, rdata, first_hit);
                check_value("second tag data", rdata, ref_read(32'h2010));
                mem_access(1'b0, 32'h3010, '0, rdata, first_hit);
                check_value("third tag data", rdata, ref_read(32'h3010));
                mem_access(1'b0, 32'h1010, '0, rdata, first_hit);
                check_value("refilled dirty word", rdata, 32'h1234abcd);
                for (int i = start; i < wr_addr_q.size(); i++) begin
                        if ((wr_addr_q[i] == 32'h1010) && (wr_data_q[i] == 32'h1234abcd))
                                seen = 1'b1;
                end
                check_value("write-back of evicted word seen", 32'(seen), 32'd1);
        endtask

        task automatic random_mix();
                logic [WORD_W-1:0] addr;
                logic [WORD_W-1:0] wdata;
                logic [WORD_W-1:0] rdata;
                logic              first_hit;
                logic              is_store;
                for (int n = 0; n < RANDOM_OPS; n++) begin
                        rand_state = lcg_next(rand_state);
                        is_store   = rand_state[27];
                        addr       = {24'h0, rand_state[21:16], 2'b00};
                        rand_state = lcg_next(rand_state);
                        wdata      = rand_state;
                        mem_access(is_store, addr, wdata, rdata, first_hit);
                        if (!is_store)
                                check_value("random load", rdata, ref_read(addr));
                end
        endtask

        task automatic halt_and_flush();
                int start;
                start = wr_addr_q.size();
                @(negedge CLK);
                halt = 1'b1;
                #1;
                while (!flushed) begin
                        @(negedge CLK);
                        #1;
                end
                for (int i = start; i < wr_addr_q.size(); i++) begin
                        if (wr_addr_q[i] == HIT_COUNT_ADDR)
                                check_value("hit count", wr_data_q[i], 32'(hits));
                        else
                                check_value("flushed word", wr_data_q[i], ref_read(wr_addr_q[i]));
                end
                check_value("last write address", wr_addr_q[wr_addr_q.size() - 1], HIT_COUNT_ADDR);
                foreach (ref_mem[a])
                        check_value("memory after flush", image_read(a), ref_mem[a]);
                repeat (16) begin
                        @(negedge CLK);
                        #1;
                        check_value("flushed", 32'(flushed), 32'd1);
                end
        endtask

        initial begin
                nRST      = 1'b0;
                dmemren   = 1'b0;
                dmemwen   = 1'b0;
                dmemaddr  = '0;
                dmemstore = '0;
                halt      = 1'b0;
                repeat (10) @(negedge CLK);
                nRST = 1'b1;
                read_miss_then_hit();
                store_then_load();
                evict_dirty_line();
                random_mix();
                halt_and_flush();
                $display("Simulation passed");
                $finish;
        end

endmodule

`default_nettype wire
